//--- hdl/trace_pkg.sv
package trace_pkg;

    //////////////////////////////
    // pipeline geometry
    //////////////////////////////

    // fetch, decode, execute, memory, write-back
    localparam int NUM_STAGES = 5;

    // ids wrap mod 16, well above the five in flight
    localparam int ID_W        = 4;
    localparam int TRACE_DEPTH = 16;
    localparam int INFO_W      = 16;

    // stage indices into valid/id arrays and mask bits
    localparam int STG_FETCH  = 0;
    localparam int STG_DECODE = 1;
    localparam int STG_EXEC   = 2;
    localparam int STG_MEM    = 3;
    localparam int STG_WB     = 4;

    typedef logic [ID_W-1:0]   id_t;
    typedef logic [INFO_W-1:0] info_t;

    //////////////////////////////
    // config register map
    //////////////////////////////

    // width of the config data path
    localparam int CFG_W = 16;

    localparam logic [1:0] REG_CTRL  = 2'd0;
    localparam logic [1:0] REG_MASK  = 2'd1;
    localparam logic [1:0] REG_COUNT = 2'd2;

endpackage

//--- hdl/stage_tag_if.sv
`timescale 1ns/1ps

interface stage_tag_if;

    //////////////////////////////
    // per-stage tags
    //////////////////////////////

    // one valid bit per stage, index by trace_pkg::STG_*
    logic [trace_pkg::NUM_STAGES-1:0] valid;

    // id of the instruction held in each stage
    trace_pkg::id_t [trace_pkg::NUM_STAGES-1:0] id;

    // stages move at the coming edge
    logic advance;

    // tracker owns the tags
    modport tracker (
        output valid,
        output id,
        output advance
    );

    // store only needs where each instruction sits
    modport store (
        input valid,
        input id
    );

    // emitter also watches for departure from write-back
    modport emitter (
        input valid,
        input id,
        input advance
    );

endinterface

//--- hdl/stage_tracker.sv
`timescale 1ns/1ps

module stage_tracker (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    stage_tag_if.tracker tags
);

    //////////////////////////////
    // stage registers
    //////////////////////////////

    // valid bit per stage
    logic [trace_pkg::NUM_STAGES-1:0] valid_q;

    // id per stage
    // entry STG_FETCH doubles as the fetch id counter
    trace_pkg::id_t [trace_pkg::NUM_STAGES-1:0] id_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            id_q    <= '0;
        end else if (!stall) begin
            // new instruction enters fetch with the next id
            valid_q[trace_pkg::STG_FETCH] <= 1'b1;
            id_q[trace_pkg::STG_FETCH]    <= id_q[trace_pkg::STG_FETCH] + 1'b1;

            // every later stage takes what the one before held
            for (int s = trace_pkg::STG_DECODE; s <= trace_pkg::STG_WB; s++) begin
                valid_q[s] <= valid_q[s-1];
                id_q[s]    <= id_q[s-1];
            end
        end else begin
            // bubble at fetch, decode through write-back frozen
            // fetch id is kept so the next advance moves on from it
            valid_q[trace_pkg::STG_FETCH] <= 1'b0;
        end
    end

    //////////////////////////////
    // tag outputs
    //////////////////////////////

    assign tags.valid = valid_q;
    assign tags.id    = id_q;

    // the pipeline moves whenever the CPU is not frozen
    assign tags.advance = !stall;

endmodule

//--- hdl/trace_store.sv
`timescale 1ns/1ps

module trace_store (
    input  logic             clk,
    stage_tag_if.store       tags,
    input  trace_pkg::info_t fetch_info,
    input  trace_pkg::info_t decode_info,
    input  trace_pkg::info_t exec_info,
    input  trace_pkg::info_t mem_info,
    output trace_pkg::info_t rd_fetch,
    output trace_pkg::info_t rd_decode,
    output trace_pkg::info_t rd_exec,
    output trace_pkg::info_t rd_mem
);

    //////////////////////////////
    // record memory
    //////////////////////////////

    // one entry per id, one field per stage fetch..mem
    // write-back info never lands here, the emitter samples it live
    trace_pkg::info_t [trace_pkg::STG_MEM:trace_pkg::STG_FETCH]
        rec_mem [trace_pkg::TRACE_DEPTH];

    // incoming info lined up by stage index
    trace_pkg::info_t [trace_pkg::STG_MEM:trace_pkg::STG_FETCH] wr_info;

    assign wr_info[trace_pkg::STG_FETCH]  = fetch_info;
    assign wr_info[trace_pkg::STG_DECODE] = decode_info;
    assign wr_info[trace_pkg::STG_EXEC]   = exec_info;
    assign wr_info[trace_pkg::STG_MEM]    = mem_info;

    // each valid stage writes its own field under its own id
    // ids in flight are distinct, so entries never collide
    // a held stage simply rewrites its field with the latest info
    always_ff @(posedge clk) begin
        for (int s = trace_pkg::STG_FETCH; s <= trace_pkg::STG_MEM; s++) begin
            if (tags.valid[s]) begin
                rec_mem[tags.id[s]][s] <= wr_info[s];
            end
        end
    end

    //////////////////////////////
    // readback at write-back id
    //////////////////////////////

    // the mem field was written on the edge that moved it into wb
    trace_pkg::id_t wb_id;

    assign wb_id = tags.id[trace_pkg::STG_WB];

    assign rd_fetch  = rec_mem[wb_id][trace_pkg::STG_FETCH];
    assign rd_decode = rec_mem[wb_id][trace_pkg::STG_DECODE];
    assign rd_exec   = rec_mem[wb_id][trace_pkg::STG_EXEC];
    assign rd_mem    = rec_mem[wb_id][trace_pkg::STG_MEM];

endmodule

//--- hdl/retire_emitter.sv
`timescale 1ns/1ps

module retire_emitter (
    input  logic                             clk,
    input  logic                             rst,
    stage_tag_if.emitter                     tags,
    input  trace_pkg::info_t                 rd_fetch,
    input  trace_pkg::info_t                 rd_decode,
    input  trace_pkg::info_t                 rd_exec,
    input  trace_pkg::info_t                 rd_mem,
    input  trace_pkg::info_t                 wb_info,
    input  logic                             enable,
    input  logic [trace_pkg::NUM_STAGES-1:0] stage_mask,
    output logic                             retire_strobe,
    output trace_pkg::id_t                   retire_id,
    output trace_pkg::info_t                 retire_fetch,
    output trace_pkg::info_t                 retire_decode,
    output trace_pkg::info_t                 retire_exec,
    output trace_pkg::info_t                 retire_mem,
    output trace_pkg::info_t                 retire_wb
);

    // instruction leaves write-back at this edge
    logic leaving;
    logic fire;

    assign leaving = tags.valid[trace_pkg::STG_WB] && tags.advance;
    assign fire    = leaving && enable;

    // one pulse per departure, never repeated while wb is frozen
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_strobe <= 1'b0;
        end else begin
            retire_strobe <= fire;
        end
    end

    //////////////////////////////
    // record capture
    //////////////////////////////

    // outputs keep the last retired record between strobes
    // masked stages read as zero
    always_ff @(posedge clk) begin
        if (fire) begin
            retire_id     <= tags.id[trace_pkg::STG_WB];
            retire_fetch  <= stage_mask[trace_pkg::STG_FETCH]  ? rd_fetch  : '0;
            retire_decode <= stage_mask[trace_pkg::STG_DECODE] ? rd_decode : '0;
            retire_exec   <= stage_mask[trace_pkg::STG_EXEC]   ? rd_exec   : '0;
            retire_mem    <= stage_mask[trace_pkg::STG_MEM]    ? rd_mem    : '0;
            retire_wb     <= stage_mask[trace_pkg::STG_WB]     ? wb_info   : '0;
        end
    end

endmodule

//--- hdl/trace_ctrl_regs.sv
`timescale 1ns/1ps

module trace_ctrl_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cfg_wr,
    input  logic [1:0]                       cfg_addr,
    input  logic [trace_pkg::CFG_W-1:0]      cfg_wdata,
    input  logic                             retire_strobe,
    output logic [trace_pkg::CFG_W-1:0]      cfg_rdata,
    output logic                             enable,
    output logic [trace_pkg::NUM_STAGES-1:0] stage_mask
);

    //////////////////////////////
    // CTRL and MASK
    //////////////////////////////

    // tracing on and every stage visible out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            enable     <= 1'b1;
            stage_mask <= '1;
        end else if (cfg_wr) begin
            if (cfg_addr == trace_pkg::REG_CTRL) begin
                enable <= cfg_wdata[0];
            end
            if (cfg_addr == trace_pkg::REG_MASK) begin
                stage_mask <= cfg_wdata[trace_pkg::NUM_STAGES-1:0];
            end
        end
    end

    //////////////////////////////
    // COUNT
    //////////////////////////////

    // retirements seen, wraps at 16 bits
    logic [trace_pkg::CFG_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (retire_strobe) begin
            count_q <= count_q + 1'b1;
        end
    end

    // readback mux, unused bits and addresses read zero
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            trace_pkg::REG_CTRL:  cfg_rdata[0] = enable;
            trace_pkg::REG_MASK:  cfg_rdata[trace_pkg::NUM_STAGES-1:0] = stage_mask;
            trace_pkg::REG_COUNT: cfg_rdata = count_q;
            default:              cfg_rdata = '0;
        endcase
    end

endmodule

//--- hdl/pipe_trace_top.sv
`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  trace_pkg::info_t            fetch_info,
    input  trace_pkg::info_t            decode_info,
    input  trace_pkg::info_t            exec_info,
    input  trace_pkg::info_t            mem_info,
    input  trace_pkg::info_t            wb_info,
    input  logic                        cfg_wr,
    input  logic [1:0]                  cfg_addr,
    input  logic [trace_pkg::CFG_W-1:0] cfg_wdata,
    output logic [trace_pkg::CFG_W-1:0] cfg_rdata,
    output logic                        retire_strobe,
    output trace_pkg::id_t              retire_id,
    output trace_pkg::info_t            retire_fetch,
    output trace_pkg::info_t            retire_decode,
    output trace_pkg::info_t            retire_exec,
    output trace_pkg::info_t            retire_mem,
    output trace_pkg::info_t            retire_wb
);

    // stage tags from tracker to store and emitter
    stage_tag_if tags ();

    // stored fields of the instruction now in wb
    trace_pkg::info_t rd_fetch;
    trace_pkg::info_t rd_decode;
    trace_pkg::info_t rd_exec;
    trace_pkg::info_t rd_mem;

    // configuration into the emitter
    logic                             enable;
    logic [trace_pkg::NUM_STAGES-1:0] stage_mask;

    //////////////////////////////
    // blocks
    //////////////////////////////

    stage_tracker tracker_i (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .tags  (tags.tracker)
    );

    trace_store store_i (
        .clk         (clk),
        .tags        (tags.store),
        .fetch_info  (fetch_info),
        .decode_info (decode_info),
        .exec_info   (exec_info),
        .mem_info    (mem_info),
        .rd_fetch    (rd_fetch),
        .rd_decode   (rd_decode),
        .rd_exec     (rd_exec),
        .rd_mem      (rd_mem)
    );

    // the strobe also serves as the retire pulse into COUNT
    retire_emitter emitter_i (
        .clk           (clk),
        .rst           (rst),
        .tags          (tags.emitter),
        .rd_fetch      (rd_fetch),
        .rd_decode     (rd_decode),
        .rd_exec       (rd_exec),
        .rd_mem        (rd_mem),
        .wb_info       (wb_info),
        .enable        (enable),
        .stage_mask    (stage_mask),
        .retire_strobe (retire_strobe),
        .retire_id     (retire_id),
        .retire_fetch  (retire_fetch),
        .retire_decode (retire_decode),
        .retire_exec   (retire_exec),
        .retire_mem    (retire_mem),
        .retire_wb     (retire_wb)
    );

    trace_ctrl_regs regs_i (
        .clk           (clk),
        .rst           (rst),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .retire_strobe (retire_strobe),
        .cfg_rdata     (cfg_rdata),
        .enable        (enable),
        .stage_mask    (stage_mask)
    );

endmodule

//--- testbench/pipe_trace_sva.sv
`timescale 1ns/1ps

module pipe_trace_sva (
    input logic                             clk,
    input logic                             rst,
    input logic                             stall,
    input logic [trace_pkg::NUM_STAGES-1:0] valid,
    input logic                             strobe,
    input trace_pkg::id_t                   strobe_id
);

    // back-to-back strobes must carry different ids
    assert property (@(posedge clk) disable iff (rst)
        strobe && $past(strobe) |-> strobe_id != $past(strobe_id))
        else $error("retire strobe repeated for id %0h", strobe_id);

    // frozen stages only hold, fetch turns into a bubble
    assert property (@(posedge clk) disable iff (rst)
        stall |=> (valid & ~$past(valid)) == '0)
        else $error("stage valid rose during stall");

    // nothing in flight and nothing retiring right after reset
    assert property (@(posedge clk)
        $past(rst) |-> !strobe && valid == '0)
        else $error("outputs not quiet after reset");

endmodule

//////////////////////////////
// attach to tracker and emitter
//////////////////////////////

// tracker has no strobe, those checks stay vacuous here
bind stage_tracker pipe_trace_sva tracker_sva_i (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .valid     (valid_q),
    .strobe    (1'b0),
    .strobe_id ('0)
);

// emitter side checks the strobe only
bind retire_emitter pipe_trace_sva emitter_sva_i (
    .clk       (clk),
    .rst       (rst),
    .stall     (1'b0),
    .valid     ('0),
    .strobe    (retire_strobe),
    .strobe_id (retire_id)
);

//--- testbench/tb_pipe_trace.sv
`timescale 1ns/1ps

module tb_pipe_trace;

    // one expected or observed retirement
    typedef struct packed {
        trace_pkg::id_t                               id;
        trace_pkg::info_t [trace_pkg::NUM_STAGES-1:0] f;
    } record_t;

    logic                        clk;
    logic                        rst;
    logic                        stall;
    logic                        cfg_wr;
    logic [1:0]                  cfg_addr;
    logic [trace_pkg::CFG_W-1:0] cfg_wdata;
    logic [trace_pkg::CFG_W-1:0] cfg_rdata;
    logic                        retire_strobe;
    trace_pkg::id_t              retire_id;

    // stage info in and retired fields out are both indexed by stage
    trace_pkg::info_t [trace_pkg::NUM_STAGES-1:0] info;
    trace_pkg::info_t [trace_pkg::NUM_STAGES-1:0] ret;

    //////////////////////////////
    // reference model state
    //////////////////////////////

    logic [trace_pkg::NUM_STAGES-1:0]              m_valid;
    trace_pkg::id_t [trace_pkg::NUM_STAGES-1:0]    m_id;
    trace_pkg::info_t [trace_pkg::STG_MEM:0]       m_table [trace_pkg::TRACE_DEPTH];
    logic                                          m_enable;
    logic [trace_pkg::NUM_STAGES-1:0]              m_mask;
    record_t                                       exp_q [$];
    record_t                                       exp_rec;

    int             stall_pct;
    int             strobes;
    int             checks;
    int             errors;
    int             test_num;
    int             test_errors;
    int             idle_start;
    trace_pkg::id_t first_id;
    logic [4:0]     mask_wr;
    string          field_names [5] = '{"retire_fetch", "retire_decode", "retire_exec",
                                        "retire_mem", "retire_wb"};

    pipe_trace_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .fetch_info    (info[trace_pkg::STG_FETCH]),
        .decode_info   (info[trace_pkg::STG_DECODE]),
        .exec_info     (info[trace_pkg::STG_EXEC]),
        .mem_info      (info[trace_pkg::STG_MEM]),
        .wb_info       (info[trace_pkg::STG_WB]),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .retire_strobe (retire_strobe),
        .retire_id     (retire_id),
        .retire_fetch  (ret[trace_pkg::STG_FETCH]),
        .retire_decode (ret[trace_pkg::STG_DECODE]),
        .retire_exec   (ret[trace_pkg::STG_EXEC]),
        .retire_mem    (ret[trace_pkg::STG_MEM]),
        .retire_wb     (ret[trace_pkg::STG_WB])
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // CPU stand-in with fresh info every cycle and stall at stall_pct percent
    always @(posedge clk) begin
        stall <= ($urandom % 100) < stall_pct;
        for (int s = 0; s < trace_pkg::NUM_STAGES; s++) begin
            info[s] <= trace_pkg::info_t'($urandom);
        end
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////
    // model and scoreboard
    //////////////////////////////

    // model runs at negedge where inputs already hold what the coming edge samples
    always @(negedge clk) begin
        if (rst) begin
            m_valid  = '0;
            m_id     = '0;
            m_enable = 1'b1;
            m_mask   = '1;
            exp_q.delete();
        end else begin
            // strobe visible now belongs to the oldest queued record
            if (retire_strobe) begin
                strobes++;
                if (strobes == 1) begin
                    first_id = retire_id;
                end
                checks++;
                assert (exp_q.size() != 0) else begin
                    $display("unexpected retire strobe at %0t for id %0h", $time, retire_id);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_rec = exp_q.pop_front();
                    check_value("retire_id", 16'(retire_id), 16'(exp_rec.id));
                    for (int s = 0; s < trace_pkg::NUM_STAGES; s++) begin
                        check_value(field_names[s], ret[s], exp_rec.f[s]);
                    end
                end
            end
            // instruction in wb leaves at the coming edge
            if (m_valid[trace_pkg::STG_WB] && !stall && m_enable) begin
                exp_rec.id = m_id[trace_pkg::STG_WB];
                for (int s = 0; s < trace_pkg::STG_WB; s++) begin
                    exp_rec.f[s] = m_mask[s] ? m_table[exp_rec.id][s] : '0;
                end
                exp_rec.f[trace_pkg::STG_WB] = m_mask[trace_pkg::STG_WB] ?
                                               info[trace_pkg::STG_WB] : '0;
                exp_q.push_back(exp_rec);
            end
            // last info seen in each stage up to mem
            for (int s = 0; s <= trace_pkg::STG_MEM; s++) begin
                if (m_valid[s]) begin
                    m_table[m_id[s]][s] = info[s];
                end
            end
            if (!stall) begin
                for (int s = trace_pkg::STG_WB; s > trace_pkg::STG_FETCH; s--) begin
                    m_valid[s] = m_valid[s-1];
                    m_id[s]    = m_id[s-1];
                end
                m_valid[trace_pkg::STG_FETCH] = 1'b1;
                m_id[trace_pkg::STG_FETCH]    = m_id[trace_pkg::STG_FETCH] + 1'b1;
            end else begin
                // fetch becomes a bubble while the rest freeze
                m_valid[trace_pkg::STG_FETCH] = 1'b0;
            end
            // config writes land at the coming edge too
            if (cfg_wr && cfg_addr == trace_pkg::REG_CTRL) begin
                m_enable = cfg_wdata[0];
            end
            if (cfg_wr && cfg_addr == trace_pkg::REG_MASK) begin
                m_mask = cfg_wdata[trace_pkg::NUM_STAGES-1:0];
            end
        end
    end

    //////////////////////////////
    // bus and wait helpers
    //////////////////////////////

    task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr    <= 1'b0;
    endtask

    // readback is combinational and sampled mid-cycle
    task automatic read_reg(input logic [1:0] addr, input string name,
                            input logic [15:0] exp);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        check_value(name, cfg_rdata, exp);
    endtask

    // scoreboard counters settle at negedge and are read at posedge
    task automatic wait_retires(input int n);
        int target;
        int cycles;
        target = strobes + n;
        cycles = 0;
        while (strobes < target && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        checks++;
        assert (strobes >= target) else begin
            $display("timeout: only %0d of %0d retirements arrived", n - (target - strobes), n);
            errors++;
        end
    endtask

    // until every queued record has retired
    task automatic wait_quiet();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("timeout: %0d expected retirements never drained", exp_q.size());
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
        test_num++;
        test_errors = errors;
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        void'($urandom(15));
        rst         = 1'b1;
        stall       = 1'b0;
        info        = '0;
        cfg_wr      = 1'b0;
        cfg_addr    = trace_pkg::REG_CTRL;
        cfg_wdata   = '0;
        stall_pct   = 0;
        strobes     = 0;
        checks      = 0;
        errors      = 0;
        test_num    = 1;
        test_errors = 0;
        first_id    = '0;
        mask_wr     = '1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // free-running pipeline with ids starting at 1
        wait_retires(20);
        check_value("first retire_id", 16'(first_id), 16'd1);
        end_test("no stall");

        stall_pct = 25;
        wait_retires(40);
        end_test("random stall");

        // mask is never all ones so at least one field is masked
        mask_wr = 5'($urandom % 31);
        write_reg(trace_pkg::REG_MASK, 16'(mask_wr));
        wait_retires(16);
        end_test("stage mask");

        // drain and then watch an idle window with tracing off
        write_reg(trace_pkg::REG_CTRL, 16'd0);
        wait_quiet();
        idle_start = strobes;
        repeat (40) @(posedge clk);
        check_value("strobes while disabled", 16'(strobes - idle_start), 16'd0);
        write_reg(trace_pkg::REG_CTRL, 16'd1);
        wait_retires(12);
        end_test("enable");

        // freeze COUNT before reading it
        write_reg(trace_pkg::REG_CTRL, 16'd0);
        wait_quiet();
        read_reg(trace_pkg::REG_COUNT, "COUNT", 16'(strobes));
        read_reg(trace_pkg::REG_CTRL, "CTRL", 16'd0);
        read_reg(trace_pkg::REG_MASK, "MASK", 16'(mask_wr));
        write_reg(trace_pkg::REG_CTRL, 16'd1);
        read_reg(trace_pkg::REG_CTRL, "CTRL", 16'd1);
        end_test("register readback");

        $display("%0d tests, %0d checks, %0d errors", test_num - 1, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/trace_pkg.sv
hdl/stage_tag_if.sv
hdl/stage_tracker.sv
hdl/trace_store.sv
hdl/retire_emitter.sv
hdl/trace_ctrl_regs.sv
hdl/pipe_trace_top.sv
testbench/pipe_trace_sva.sv
testbench/tb_pipe_trace.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_pipe_trace

status=0
./obj_dir/Vtb_pipe_trace > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation failed"
    exit 1
fi
